// File: hdl/soc_bus_params.svh
`ifndef SOC_BUS_PARAMS_SVH
`define SOC_BUS_PARAMS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W (`SOC_DATA_W / 8)

// request queue and memory sizes
`define SOC_FIFO_DEPTH 4
`define SOC_SRAM_WORDS 256

// device map
`define SOC_SERIAL_ADDR 32'ha000_03f8
`define SOC_RTC_ADDR 32'ha000_0048
`define SOC_RTC_ADDR_UP 32'ha000_004c

// serial port recovery time in cycles
`define SOC_SERIAL_BUSY 3

`endif

// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

  // who issued a request
  typedef enum logic {
    SRC_IFU = 1'b0,
    SRC_LSU = 1'b1
  } src_e;

  // target picked by the address decoder
  typedef enum logic [1:0] {
    DEV_SRAM   = 2'd0,
    DEV_SERIAL = 2'd1,
    DEV_RTC    = 2'd2
  } dev_e;

  // timer counts as one word, bus reads it in halves
  typedef union packed {
    logic [63:0] count;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } mtime_u;

endpackage

// File: hdl/mem_sram.sv
`timescale 1ns/1ps
`include "soc_bus_params.svh"

module mem_sram (
  input  logic                   clk,
  input  logic                   en_i,
  input  logic                   we_i,
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  input  logic [`SOC_STRB_W-1:0] wstrb_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_SRAM_WORDS];
  logic [IDX_W-1:0]       idx;

  // drop the byte offset, upper bits wrap
  assign idx = addr_i[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < `SOC_STRB_W; b++) begin
          if (wstrb_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/1ps

module clint_timer import soc_bus_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  output mtime_u mtime_o
);

  mtime_u mtime_q;

  assign mtime_o = mtime_q;

  // free running, wraps after 2^64 cycles
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mtime_q.count <= '0;
    end else begin
      mtime_q.count <= mtime_q.count + 64'd1;
    end
  end

endmodule

// File: hdl/serial_port.sv
`timescale 1ns/1ps
`include "soc_bus_params.svh"

module serial_port (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       char_valid_i,
  input  logic [7:0] char_data_i,
  output logic       char_ready_o,
  output logic [7:0] uart_char_o,
  output logic       uart_char_valid_o
);

  localparam int BUSY_W = $clog2(`SOC_SERIAL_BUSY + 1);

  logic [BUSY_W-1:0] busy_cnt_q;

  // not ready while the character goes out or the line recovers
  assign char_ready_o = (busy_cnt_q == '0) & ~uart_char_valid_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      uart_char_valid_o <= 1'b0;
      busy_cnt_q        <= '0;
    end else if (char_valid_i && char_ready_o) begin
      uart_char_valid_o <= 1'b1;
      busy_cnt_q        <= BUSY_W'(`SOC_SERIAL_BUSY);
    end else begin
      uart_char_valid_o <= 1'b0;
      if (!uart_char_valid_o && busy_cnt_q != '0) begin
        busy_cnt_q <= busy_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (char_valid_i && char_ready_o) begin
      uart_char_o <= char_data_i;
    end
  end

  // sender keeps the character steady until taken
  a_char_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    char_valid_i && !char_ready_o |=> char_valid_i && $stable(char_data_i));

endmodule

// File: hdl/req_fifo.sv
`timescale 1ns/1ps
`include "soc_bus_params.svh"

module req_fifo import soc_bus_pkg::*; #(
  parameter int DEPTH = `SOC_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   push_valid_i,
  input  src_e                   push_src_i,
  input  logic [`SOC_ADDR_W-1:0] push_addr_i,
  input  logic                   push_we_i,
  input  logic [`SOC_DATA_W-1:0] push_wdata_i,
  input  logic [`SOC_STRB_W-1:0] push_wstrb_i,
  output logic                   push_ready_o,
  output logic                   head_valid_o,
  output src_e                   head_src_o,
  output logic [`SOC_ADDR_W-1:0] head_addr_o,
  output logic                   head_we_o,
  output logic [`SOC_DATA_W-1:0] head_wdata_o,
  output logic [`SOC_STRB_W-1:0] head_wstrb_o,
  input  logic                   pop_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  src_e                   src_mem   [DEPTH];
  logic [`SOC_ADDR_W-1:0] addr_mem  [DEPTH];
  logic                   we_mem    [DEPTH];
  logic [`SOC_DATA_W-1:0] wdata_mem [DEPTH];
  logic [`SOC_STRB_W-1:0] wstrb_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign head_valid_o = (count_q != '0);
  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_i & head_valid_o;

  assign head_src_o   = src_mem[rd_ptr_q];
  assign head_addr_o  = addr_mem[rd_ptr_q];
  assign head_we_o    = we_mem[rd_ptr_q];
  assign head_wdata_o = wdata_mem[rd_ptr_q];
  assign head_wstrb_o = wstrb_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      src_mem[wr_ptr_q]   <= push_src_i;
      addr_mem[wr_ptr_q]  <= push_addr_i;
      we_mem[wr_ptr_q]    <= push_we_i;
      wdata_mem[wr_ptr_q] <= push_wdata_i;
      wstrb_mem[wr_ptr_q] <= push_wstrb_i;
    end
  end

  // router may only pop a real entry
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
    pop_i |-> head_valid_o);

  // when full the push must wait with the same request
  a_push_waits: assert property (@(posedge clk) disable iff (!rst_n_i)
    push_valid_i && !push_ready_o |=>
      push_valid_i && $stable(push_addr_i) && $stable(push_src_i));

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ps
`include "soc_bus_params.svh"

module bus_arbiter import soc_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`SOC_ADDR_W-1:0] ifu_araddr_i,
  input  logic                   ifu_arvalid_i,
  output logic                   ifu_arready_o,
  input  logic [`SOC_ADDR_W-1:0] lsu_addr_i,
  input  logic                   lsu_we_i,
  input  logic [`SOC_DATA_W-1:0] lsu_wdata_i,
  input  logic [`SOC_STRB_W-1:0] lsu_wstrb_i,
  input  logic                   lsu_valid_i,
  output logic                   lsu_ready_o,
  output logic                   req_valid_o,
  output src_e                   req_src_o,
  output logic [`SOC_ADDR_W-1:0] req_addr_o,
  output logic                   req_we_o,
  output logic [`SOC_DATA_W-1:0] req_wdata_o,
  output logic [`SOC_STRB_W-1:0] req_wstrb_o,
  input  logic                   req_ready_i,
  input  logic                   rsp_valid_i,
  input  src_e                   rsp_src_i,
  input  logic                   rsp_we_i,
  input  logic [`SOC_DATA_W-1:0] rsp_rdata_i,
  output logic [`SOC_DATA_W-1:0] ifu_rdata_o,
  output logic                   ifu_rvalid_o,
  output logic [`SOC_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_rvalid_o,
  output logic                   lsu_bvalid_o
);

  logic hold_q;
  src_e hold_src_q;
  src_e sel_src;

  // lsu first, but a stalled grant stays put until it goes through
  always_comb begin
    if (hold_q) begin
      sel_src = hold_src_q;
    end else if (lsu_valid_i) begin
      sel_src = SRC_LSU;
    end else begin
      sel_src = SRC_IFU;
    end
  end

  assign req_valid_o = lsu_valid_i | ifu_arvalid_i;
  assign req_src_o   = sel_src;
  assign req_addr_o  = (sel_src == SRC_LSU) ? lsu_addr_i : ifu_araddr_i;
  assign req_we_o    = (sel_src == SRC_LSU) & lsu_we_i;
  assign req_wdata_o = lsu_wdata_i;
  assign req_wstrb_o = (sel_src == SRC_LSU) ? lsu_wstrb_i : '0;

  assign lsu_ready_o   = req_ready_i & lsu_valid_i & (sel_src == SRC_LSU);
  assign ifu_arready_o = req_ready_i & ifu_arvalid_i & (sel_src == SRC_IFU);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= req_valid_o & ~req_ready_i;
    end
  end

  always_ff @(posedge clk) begin
    hold_src_q <= sel_src;
  end

  // response demux, one pulse on the port that asked
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ifu_rvalid_o <= 1'b0;
      lsu_rvalid_o <= 1'b0;
      lsu_bvalid_o <= 1'b0;
    end else begin
      ifu_rvalid_o <= rsp_valid_i & ~rsp_we_i & (rsp_src_i == SRC_IFU);
      lsu_rvalid_o <= rsp_valid_i & ~rsp_we_i & (rsp_src_i == SRC_LSU);
      lsu_bvalid_o <= rsp_valid_i & rsp_we_i & (rsp_src_i == SRC_LSU);
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid_i && !rsp_we_i) begin
      if (rsp_src_i == SRC_IFU) begin
        ifu_rdata_o <= rsp_rdata_i;
      end else begin
        lsu_rdata_o <= rsp_rdata_i;
      end
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(ifu_arready_o && lsu_ready_o));

endmodule

// File: hdl/dev_router.sv
`timescale 1ns/1ps
`include "soc_bus_params.svh"

module dev_router import soc_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   head_valid_i,
  input  src_e                   head_src_i,
  input  logic [`SOC_ADDR_W-1:0] head_addr_i,
  input  logic                   head_we_i,
  input  logic [`SOC_DATA_W-1:0] head_wdata_i,
  input  logic [`SOC_STRB_W-1:0] head_wstrb_i,
  output logic                   pop_o,
  output logic                   sram_en_o,
  output logic                   sram_we_o,
  output logic [`SOC_ADDR_W-1:0] sram_addr_o,
  output logic [`SOC_DATA_W-1:0] sram_wdata_o,
  output logic [`SOC_STRB_W-1:0] sram_wstrb_o,
  input  logic [`SOC_DATA_W-1:0] sram_rdata_i,
  input  mtime_u                 mtime_i,
  output logic                   char_valid_o,
  output logic [7:0]             char_data_o,
  input  logic                   char_ready_i,
  output logic                   rsp_valid_o,
  output src_e                   rsp_src_o,
  output logic                   rsp_we_o,
  output logic [`SOC_DATA_W-1:0] rsp_rdata_o
);

  dev_e head_dev;
  dev_e dev_q;
  src_e src_q;
  logic busy_q;
  logic we_q;
  logic char_done_q;
  logic [7:0] char_q;
  logic [`SOC_DATA_W-1:0] rtc_q;
  logic start;
  logic serial_wr;

  // address decode, anything unmapped goes to sram
  always_comb begin
    if (head_addr_i == `SOC_SERIAL_ADDR) begin
      head_dev = DEV_SERIAL;
    end else if (head_addr_i == `SOC_RTC_ADDR || head_addr_i == `SOC_RTC_ADDR_UP) begin
      head_dev = DEV_RTC;
    end else begin
      head_dev = DEV_SRAM;
    end
  end

  assign start = ~busy_q & head_valid_i;
  assign pop_o = start;

  // sram sees the head directly in the start cycle
  assign sram_en_o    = start & (head_dev == DEV_SRAM);
  assign sram_we_o    = head_we_i;
  assign sram_addr_o  = head_addr_i;
  assign sram_wdata_o = head_wdata_i;
  assign sram_wstrb_o = head_wstrb_i;

  assign serial_wr    = (dev_q == DEV_SERIAL) & we_q;
  assign char_valid_o = busy_q & serial_wr & ~char_done_q;
  assign char_data_o  = char_q;

  assign rsp_valid_o = busy_q & (~serial_wr | char_done_q);
  assign rsp_src_o   = src_q;
  assign rsp_we_o    = we_q;

  always_comb begin
    case (dev_q)
      DEV_SRAM: rsp_rdata_o = sram_rdata_i;
      DEV_RTC:  rsp_rdata_o = rtc_q;
      default:  rsp_rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      char_done_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
    end else if (rsp_valid_o) begin
      busy_q      <= 1'b0;
      char_done_q <= 1'b0;
    end else if (char_valid_o && char_ready_i) begin
      char_done_q <= 1'b1;
    end
  end

  // request fields kept for the busy phase
  always_ff @(posedge clk) begin
    if (start) begin
      dev_q  <= head_dev;
      src_q  <= head_src_i;
      we_q   <= head_we_i;
      char_q <= head_wdata_i[7:0];
      rtc_q  <= (head_addr_i == `SOC_RTC_ADDR_UP) ? mtime_i.half.hi : mtime_i.half.lo;
    end
  end

  a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_o |=> !rsp_valid_o);

endmodule

// File: hdl/soc_bus_top.sv
`timescale 1ns/1ps
`include "soc_bus_params.svh"

module soc_bus_top import soc_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`SOC_ADDR_W-1:0] ifu_araddr_i,
  input  logic                   ifu_arvalid_i,
  output logic                   ifu_arready_o,
  output logic [`SOC_DATA_W-1:0] ifu_rdata_o,
  output logic                   ifu_rvalid_o,
  input  logic [`SOC_ADDR_W-1:0] lsu_addr_i,
  input  logic                   lsu_we_i,
  input  logic [`SOC_DATA_W-1:0] lsu_wdata_i,
  input  logic [`SOC_STRB_W-1:0] lsu_wstrb_i,
  input  logic                   lsu_valid_i,
  output logic                   lsu_ready_o,
  output logic [`SOC_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_rvalid_o,
  output logic                   lsu_bvalid_o,
  output logic [7:0]             uart_char_o,
  output logic                   uart_char_valid_o
);

  // arbiter to fifo
  logic                   req_valid;
  logic                   req_ready;
  src_e                   req_src;
  logic [`SOC_ADDR_W-1:0] req_addr;
  logic                   req_we;
  logic [`SOC_DATA_W-1:0] req_wdata;
  logic [`SOC_STRB_W-1:0] req_wstrb;

  // fifo head to router
  logic                   head_valid;
  logic                   pop;
  src_e                   head_src;
  logic [`SOC_ADDR_W-1:0] head_addr;
  logic                   head_we;
  logic [`SOC_DATA_W-1:0] head_wdata;
  logic [`SOC_STRB_W-1:0] head_wstrb;

  // router back to arbiter
  logic                   rsp_valid;
  src_e                   rsp_src;
  logic                   rsp_we;
  logic [`SOC_DATA_W-1:0] rsp_rdata;

  // device side
  logic                   sram_en;
  logic                   sram_we;
  logic [`SOC_ADDR_W-1:0] sram_addr;
  logic [`SOC_DATA_W-1:0] sram_wdata;
  logic [`SOC_STRB_W-1:0] sram_wstrb;
  logic [`SOC_DATA_W-1:0] sram_rdata;
  mtime_u                 mtime;
  logic                   char_valid;
  logic [7:0]             char_data;
  logic                   char_ready;

  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_arready_o (ifu_arready_o),
    .lsu_addr_i    (lsu_addr_i),
    .lsu_we_i      (lsu_we_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_valid_i   (lsu_valid_i),
    .lsu_ready_o   (lsu_ready_o),
    .req_valid_o   (req_valid),
    .req_src_o     (req_src),
    .req_addr_o    (req_addr),
    .req_we_o      (req_we),
    .req_wdata_o   (req_wdata),
    .req_wstrb_o   (req_wstrb),
    .req_ready_i   (req_ready),
    .rsp_valid_i   (rsp_valid),
    .rsp_src_i     (rsp_src),
    .rsp_we_i      (rsp_we),
    .rsp_rdata_i   (rsp_rdata),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_bvalid_o  (lsu_bvalid_o)
  );

  req_fifo #(
    .DEPTH (`SOC_FIFO_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_valid_i (req_valid),
    .push_src_i   (req_src),
    .push_addr_i  (req_addr),
    .push_we_i    (req_we),
    .push_wdata_i (req_wdata),
    .push_wstrb_i (req_wstrb),
    .push_ready_o (req_ready),
    .head_valid_o (head_valid),
    .head_src_o   (head_src),
    .head_addr_o  (head_addr),
    .head_we_o    (head_we),
    .head_wdata_o (head_wdata),
    .head_wstrb_o (head_wstrb),
    .pop_i        (pop)
  );

  dev_router u_router (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .head_valid_i (head_valid),
    .head_src_i   (head_src),
    .head_addr_i  (head_addr),
    .head_we_i    (head_we),
    .head_wdata_i (head_wdata),
    .head_wstrb_i (head_wstrb),
    .pop_o        (pop),
    .sram_en_o    (sram_en),
    .sram_we_o    (sram_we),
    .sram_addr_o  (sram_addr),
    .sram_wdata_o (sram_wdata),
    .sram_wstrb_o (sram_wstrb),
    .sram_rdata_i (sram_rdata),
    .mtime_i      (mtime),
    .char_valid_o (char_valid),
    .char_data_o  (char_data),
    .char_ready_i (char_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_src_o    (rsp_src),
    .rsp_we_o     (rsp_we),
    .rsp_rdata_o  (rsp_rdata)
  );

  mem_sram u_sram (
    .clk     (clk),
    .en_i    (sram_en),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .wstrb_i (sram_wstrb),
    .rdata_o (sram_rdata)
  );

  clint_timer u_timer (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .mtime_o (mtime)
  );

  serial_port u_serial (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .char_valid_i      (char_valid),
    .char_data_i       (char_data),
    .char_ready_o      (char_ready),
    .uart_char_o       (uart_char_o),
    .uart_char_valid_o (uart_char_valid_o)
  );

endmodule

// File: test/tb_soc_bus.sv
`timescale 1ns/1ps
`include "soc_bus_params.svh"

module tb_soc_bus;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int NUM_WORDS = 16;
  localparam int TIMER_GAP = 20;

  logic                   clk;
  logic                   rst_n_i;
  logic [`SOC_ADDR_W-1:0] ifu_araddr_i;
  logic                   ifu_arvalid_i;
  logic                   ifu_arready_o;
  logic [`SOC_DATA_W-1:0] ifu_rdata_o;
  logic                   ifu_rvalid_o;
  logic [`SOC_ADDR_W-1:0] lsu_addr_i;
  logic                   lsu_we_i;
  logic [`SOC_DATA_W-1:0] lsu_wdata_i;
  logic [`SOC_STRB_W-1:0] lsu_wstrb_i;
  logic                   lsu_valid_i;
  logic                   lsu_ready_o;
  logic [`SOC_DATA_W-1:0] lsu_rdata_o;
  logic                   lsu_rvalid_o;
  logic                   lsu_bvalid_o;
  logic [7:0]             uart_char_o;
  logic                   uart_char_valid_o;

  integer seed = 32'hcff180e8;
  int     cycle_count = 0;
  int     error_count = 0;
  int     stall_cycles = 0;

  // reference copy of the sram contents
  logic [`SOC_DATA_W-1:0] model_mem [`SOC_SRAM_WORDS];
  logic [`SOC_ADDR_W-1:0] addr_list [$];

  // expected responses are pushed when a request is accepted
  logic [`SOC_DATA_W-1:0] exp_lsu_rdata [$];
  bit                     exp_lsu_check [$];
  logic [`SOC_DATA_W-1:0] exp_ifu_rdata [$];
  logic [7:0]             exp_chars [$];
  int issued_lsu_r = 0;
  int issued_ifu_r = 0;
  int issued_b = 0;

  // what the monitor saw
  int seen_lsu_r = 0;
  int seen_ifu_r = 0;
  int seen_b = 0;
  logic [`SOC_DATA_W-1:0] lsu_rdata_log [$];
  bit rsp_order [$];
  bit accept_order [$];

  soc_bus_top uut (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .ifu_araddr_i      (ifu_araddr_i),
    .ifu_arvalid_i     (ifu_arvalid_i),
    .ifu_arready_o     (ifu_arready_o),
    .ifu_rdata_o       (ifu_rdata_o),
    .ifu_rvalid_o      (ifu_rvalid_o),
    .lsu_addr_i        (lsu_addr_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_wdata_i       (lsu_wdata_i),
    .lsu_wstrb_i       (lsu_wstrb_i),
    .lsu_valid_i       (lsu_valid_i),
    .lsu_ready_o       (lsu_ready_o),
    .lsu_rdata_o       (lsu_rdata_o),
    .lsu_rvalid_o      (lsu_rvalid_o),
    .lsu_bvalid_o      (lsu_bvalid_o),
    .uart_char_o       (uart_char_o),
    .uart_char_valid_o (uart_char_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("Failure at %0t: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // word index is the address above the byte offset modulo the depth
  function automatic int word_index(input logic [`SOC_ADDR_W-1:0] addr);
    return (addr >> 2) % `SOC_SRAM_WORDS;
  endfunction

  // response monitor matches each pulse against the expected queues
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (lsu_rvalid_o) begin
        if (exp_lsu_rdata.size() == 0) begin
          report_failure("read data on the lsu port with no lsu read pending");
        end else begin
          lsu_rdata_log.push_back(lsu_rdata_o);
          if (exp_lsu_check.pop_front()) begin
            check_value("lsu_rdata_o", lsu_rdata_o, exp_lsu_rdata.pop_front());
          end else begin
            void'(exp_lsu_rdata.pop_front());
          end
          seen_lsu_r++;
          rsp_order.push_back(1'b1);
        end
      end
      if (ifu_rvalid_o) begin
        if (exp_ifu_rdata.size() == 0) begin
          report_failure("read data on the fetch port with no fetch pending");
        end else begin
          check_value("ifu_rdata_o", ifu_rdata_o, exp_ifu_rdata.pop_front());
          seen_ifu_r++;
          rsp_order.push_back(1'b0);
        end
      end
      if (lsu_bvalid_o) begin
        if (seen_b >= issued_b) begin
          report_failure("write response with no write pending");
        end else begin
          seen_b++;
          rsp_order.push_back(1'b1);
        end
      end
      if (uart_char_valid_o) begin
        if (exp_chars.size() == 0) begin
          report_failure("serial port sent a character nobody wrote");
        end else begin
          check_value("uart_char_o", uart_char_o, exp_chars.pop_front());
        end
      end
    end
  end

  // expected effect of an accepted lsu request on each device
  task automatic record_lsu(input logic [`SOC_ADDR_W-1:0] addr, input logic we,
                            input logic [`SOC_DATA_W-1:0] wdata,
                            input logic [`SOC_STRB_W-1:0] wstrb);
    int idx;
    idx = word_index(addr);
    if (we) begin
      issued_b++;
      if (addr == `SOC_SERIAL_ADDR) begin
        exp_chars.push_back(wdata[7:0]);
      end else if (addr != `SOC_RTC_ADDR && addr != `SOC_RTC_ADDR_UP) begin
        for (int b = 0; b < `SOC_STRB_W; b++) begin
          if (wstrb[b]) begin
            model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end
    end else begin
      issued_lsu_r++;
      if (addr == `SOC_SERIAL_ADDR || addr == `SOC_RTC_ADDR_UP) begin
        // serial reads as zero and the upper timer half stays zero in a short run
        exp_lsu_rdata.push_back('0);
        exp_lsu_check.push_back(1'b1);
      end else if (addr == `SOC_RTC_ADDR) begin
        exp_lsu_rdata.push_back('0);
        exp_lsu_check.push_back(1'b0);
      end else begin
        exp_lsu_rdata.push_back(model_mem[idx]);
        exp_lsu_check.push_back(1'b1);
      end
    end
  endtask

  // valid stays high until drain_bus or the next issue changes it
  task automatic lsu_issue(input logic [`SOC_ADDR_W-1:0] addr, input logic we,
                           input logic [`SOC_DATA_W-1:0] wdata,
                           input logic [`SOC_STRB_W-1:0] wstrb);
    @(negedge clk);
    lsu_valid_i = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_wdata_i = wdata;
    lsu_wstrb_i = wstrb;
    @(posedge clk);
    while (!lsu_ready_o) begin
      stall_cycles++;
      @(posedge clk);
    end
    record_lsu(addr, we, wdata, wstrb);
  endtask

  task automatic ifu_issue(input logic [`SOC_ADDR_W-1:0] addr);
    @(negedge clk);
    ifu_arvalid_i = 1'b1;
    ifu_araddr_i  = addr;
    @(posedge clk);
    while (!ifu_arready_o) begin
      @(posedge clk);
    end
    exp_ifu_rdata.push_back(model_mem[word_index(addr)]);
    issued_ifu_r++;
  endtask

  task automatic drain_bus();
    @(negedge clk);
    lsu_valid_i   = 1'b0;
    ifu_arvalid_i = 1'b0;
    @(posedge clk);
    while (seen_lsu_r != issued_lsu_r || seen_ifu_r != issued_ifu_r ||
           seen_b != issued_b || exp_chars.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic sram_write_read();
    logic [`SOC_ADDR_W-1:0] addr;
    check_value("ifu_rvalid_o", ifu_rvalid_o, 0);
    check_value("lsu_rvalid_o", lsu_rvalid_o, 0);
    check_value("lsu_bvalid_o", lsu_bvalid_o, 0);
    check_value("uart_char_valid_o", uart_char_valid_o, 0);
    check_value("ifu_arready_o", ifu_arready_o, 0);
    check_value("lsu_ready_o", lsu_ready_o, 0);
    for (int i = 0; i < NUM_WORDS; i++) begin
      addr = $random(seed) & 32'h0000_fffc;
      addr_list.push_back(addr);
      lsu_issue(addr, 1'b1, $random(seed), 4'hf);
    end
    drain_bus();
    foreach (addr_list[i]) begin
      lsu_issue(addr_list[i], 1'b0, '0, '0);
    end
    drain_bus();
  endtask

  task automatic byte_strobe_writes();
    logic [`SOC_STRB_W-1:0] strobes [4];
    strobes = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
    for (int i = 0; i < 4; i++) begin
      lsu_issue(addr_list[i], 1'b1, $random(seed), strobes[i]);
    end
    for (int i = 0; i < 4; i++) begin
      lsu_issue(addr_list[i], 1'b0, '0, '0);
    end
    drain_bus();
  endtask

  // any lsu_rvalid_o pulse here has no pending lsu read and fails in the monitor
  task automatic fetch_reads();
    for (int i = 0; i < 8; i++) begin
      ifu_issue(addr_list[i]);
    end
    drain_bus();
  endtask

  task automatic priority_and_order();
    rsp_order.delete();
    accept_order.delete();
    for (int r = 0; r < 4; r++) begin
      @(negedge clk);
      lsu_valid_i   = 1'b1;
      lsu_we_i      = 1'b0;
      lsu_addr_i    = addr_list[r];
      ifu_arvalid_i = 1'b1;
      ifu_araddr_i  = addr_list[r + 4];
      @(posedge clk);
      while (!lsu_ready_o && !ifu_arready_o) begin
        @(posedge clk);
      end
      // the first grant with both valid must go to the lsu
      check_value("lsu_ready_o", lsu_ready_o, 1);
      check_value("ifu_arready_o", ifu_arready_o, 0);
      record_lsu(addr_list[r], 1'b0, '0, '0);
      accept_order.push_back(1'b1);
      @(negedge clk);
      lsu_valid_i = 1'b0;
      @(posedge clk);
      while (!ifu_arready_o) begin
        @(posedge clk);
      end
      exp_ifu_rdata.push_back(model_mem[word_index(addr_list[r + 4])]);
      issued_ifu_r++;
      accept_order.push_back(1'b0);
    end
    drain_bus();
    check_value("response count", rsp_order.size(), accept_order.size());
    foreach (accept_order[i]) begin
      check_value("response source", rsp_order[i], accept_order[i]);
    end
  endtask

  task automatic serial_burst();
    logic [`SOC_ADDR_W-1:0] alias_addr;
    alias_addr = `SOC_SERIAL_ADDR & 32'h0000_ffff;
    // sram word with the same index as the serial port
    lsu_issue(alias_addr, 1'b1, $random(seed), 4'hf);
    drain_bus();
    stall_cycles = 0;
    for (int i = 0; i < 8; i++) begin
      lsu_issue(`SOC_SERIAL_ADDR, 1'b1, $random(seed), 4'hf);
    end
    lsu_issue(`SOC_SERIAL_ADDR, 1'b0, '0, '0);
    drain_bus();
    if (stall_cycles == 0) begin
      report_failure("lsu_ready_o never dropped during the serial burst");
    end
    lsu_issue(alias_addr, 1'b0, '0, '0);
    drain_bus();
  endtask

  task automatic timer_reads();
    logic [`SOC_DATA_W-1:0] t0;
    logic [`SOC_DATA_W-1:0] t1;
    logic [`SOC_DATA_W-1:0] t2;
    logic [`SOC_DATA_W-1:0] t3;
    lsu_issue(`SOC_RTC_ADDR, 1'b0, '0, '0);
    drain_bus();
    t0 = lsu_rdata_log[$];
    repeat (TIMER_GAP) @(posedge clk);
    lsu_issue(`SOC_RTC_ADDR, 1'b0, '0, '0);
    drain_bus();
    t1 = lsu_rdata_log[$];
    check_value("mtime lo advanced by the gap", (t1 - t0) >= TIMER_GAP, 1);
    lsu_issue(`SOC_RTC_ADDR_UP, 1'b0, '0, '0);
    lsu_issue(`SOC_RTC_ADDR_UP, 1'b0, '0, '0);
    drain_bus();
    // write is acked and ignored
    lsu_issue(`SOC_RTC_ADDR, 1'b1, $random(seed), 4'hf);
    drain_bus();
    lsu_issue(`SOC_RTC_ADDR, 1'b0, '0, '0);
    drain_bus();
    t2 = lsu_rdata_log[$];
    check_value("mtime lo after the write", t2 > t1, 1);
    repeat (TIMER_GAP) @(posedge clk);
    lsu_issue(`SOC_RTC_ADDR, 1'b0, '0, '0);
    drain_bus();
    t3 = lsu_rdata_log[$];
    check_value("mtime lo still counting", (t3 - t2) >= TIMER_GAP, 1);
  endtask

  initial begin
    rst_n_i       = 1'b0;
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_addr_i    = '0;
    lsu_we_i      = 1'b0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_valid_i   = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);

    sram_write_read();
    byte_strobe_writes();
    fetch_reads();
    priority_and_order();
    serial_burst();
    timer_reads();

    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hdl
hdl/soc_bus_pkg.sv
hdl/mem_sram.sv
hdl/clint_timer.sv
hdl/serial_port.sv
hdl/req_fifo.sv
hdl/bus_arbiter.sv
hdl/dev_router.sv
hdl/soc_bus_top.sv
test/tb_soc_bus.sv
